// File: build.f
+incdir+sim
src/risc_isa_pkg.sv
src/risc_ctrl_pkg.sv
src/alu.sv
src/register_file.sv
src/fetch_unit.sv
src/control_unit.sv
src/risc_cpu.sv
sim/tb_risc_cpu.sv

// File: sim/risc_ref_model.svh
`ifndef risc_ref_model_svh
`define risc_ref_model_svh

word_t  prog_img [256];     // program plus random fill
word_t  m_mem [256];        // model memory
word_t  m_regs [num_regs];
flags_t m_flags;
bit     m_illegal;          // model ended in a trap
word_t  exp_addr [$];       // stores in program order
word_t  exp_data [$];

function automatic word_t encode(input logic [6:0] op, input int w, input int r, input int s);
  return {op, 3'(w), 3'(r), 3'(s)};
endfunction

// ldi prelude, random body, register dump, cmp, halt
function automatic void gen_program(input bit with_illegal);
  int a;          // next free word
  int n;          // instructions so far
  int skip;       // words a pending jump may still skip
  int ill_at;     // earliest slot for the bad opcode
  bit ill_done;
  int pick;
  int k;
  for (int i = 0; i < 256; i++)
    prog_img[i] = word_t'($urandom);
  for (int i = 0; i < num_regs; i++) begin
    prog_img[2*i]   = encode(op_ldi, i, 0, 0);
    prog_img[2*i+1] = word_t'($urandom);
  end
  prog_img[15] = word_t'(16'h00c0 + $urandom_range(31, 0));  // R7 store pointer
  a        = 16;
  n        = 8;
  skip     = 0;
  ill_done = !with_illegal;
  ill_at   = 8 + $urandom_range(8, 0);
  while (n < 23) begin
    pick = $urandom_range(13, 0);
    if (!ill_done && n >= ill_at)
      pick = (skip == 0) ? 14 : pick % 10;  // no jump may pass over the trap
    if (pick == 13 && skip != 0)
      pick = 0;                             // ldi data word is never a target
    if (skip > 0)
      skip--;
    case (pick)
      8: prog_img[a] = encode(op_ld, $urandom_range(6, 0), 0, $urandom_range(7, 0));
      9: begin
        prog_img[a] = encode(op_sto, 7, 0, $urandom_range(7, 0));
        a++;
        n++;
        prog_img[a] = encode(op_inc, 7, 0, 7);  // step pointer
      end
      10, 11, 12: begin
        k = $urandom_range(3, 0);
        prog_img[a] = {7'(op_je + pick - 10), 9'(k)};  // forward by k
        skip = (k > skip) ? k : skip;
      end
      13: begin
        k = $urandom_range(3, 0);
        prog_img[a]   = encode(op_ldi, 6, 0, 0);
        prog_img[a+1] = word_t'(a + 3 + k);
        prog_img[a+2] = encode(op_jmp, 0, 0, 6);
        a += 2;
        n++;
        skip = k;
      end
      14: begin
        prog_img[a] = {7'($urandom_range(7'h6f, 0)), 9'($urandom)};  // below 0x70
        ill_done = 1'b1;
      end
      default: prog_img[a] = encode(7'(7'h70 + pick), $urandom_range(6, 0),
                                    $urandom_range(7, 0), $urandom_range(7, 0));
    endcase
    a++;
    n++;
  end
  for (int i = 0; i < 7; i++) begin
    prog_img[a] = encode(op_sto, 7, 0, i);  // dump R0..R6
    a++;
    if (i < 6) begin
      prog_img[a] = encode(op_inc, 7, 0, 7);
      a++;
    end
  end
  prog_img[a]   = encode(op_cmp, 0, $urandom_range(6, 0), $urandom_range(6, 0));
  prog_img[a+1] = encode(op_halt, 0, 0, 0);
endfunction

// instruction level execution of prog_img
function automatic void run_model();
  word_t       pc;
  word_t       ir;
  word_t       a;
  word_t       b;
  logic [16:0] res;   // bit 16 is carry, borrow or shifted-out bit
  bit          stop;
  int          steps;
  pc        = '0;
  m_flags   = '0;
  m_illegal = 1'b0;
  stop      = 1'b0;
  steps     = 0;
  exp_addr.delete();
  exp_data.delete();
  for (int i = 0; i < 256; i++)
    m_mem[i] = prog_img[i];
  for (int i = 0; i < num_regs; i++)
    m_regs[i] = '0;
  while (!stop && steps < 64) begin
    ir = m_mem[pc[7:0]];
    pc = pc + 16'd1;
    steps++;
    a   = m_regs[ir[5:3]];
    b   = m_regs[ir[2:0]];
    res = '0;
    case (ir[15:9])
      op_add:         res = {1'b0, a} + {1'b0, b};
      op_sub, op_cmp: res = {1'b0, a} - {1'b0, b};  // borrow when a < b
      op_shl:         res = {b[15], b << 1};
      op_shr:         res = {b[0], b >> 1};
      op_inc:         res = {b == 16'hffff, b + 16'd1};
      op_dec:         res = {b == 16'h0000, b - 16'd1};
      op_mov:         m_regs[ir[8:6]] = b;
      op_ld:          m_regs[ir[8:6]] = m_mem[b[7:0]];
      op_sto: begin
        m_mem[m_regs[ir[8:6]][7:0]] = b;
        exp_addr.push_back(m_regs[ir[8:6]]);
        exp_data.push_back(b);
      end
      op_ldi: begin
        m_regs[ir[8:6]] = m_mem[pc[7:0]];
        pc = pc + 16'd1;
      end
      op_halt: stop = 1'b1;
      op_je:   if (m_flags.z) pc = pc + {{8{ir[7]}}, ir[7:0]};
      op_jne:  if (!m_flags.z) pc = pc + {{8{ir[7]}}, ir[7:0]};
      op_jc:   if (m_flags.c) pc = pc + {{8{ir[7]}}, ir[7:0]};
      op_jmp:  pc = b;
      default: begin
        m_illegal = 1'b1;
        stop      = 1'b1;
      end
    endcase
    if (ir[15:9] inside {op_add, op_sub, op_cmp, op_shl, op_shr, op_inc, op_dec}) begin
      m_flags.n = res[15];
      m_flags.z = (res[15:0] == 16'h0000);
      m_flags.c = res[16];
      if (ir[15:9] != op_cmp)
        m_regs[ir[8:6]] = res[15:0];
    end
  end
endfunction

`endif

// File: sim/tb_risc_cpu.sv
module tb_risc_cpu
  import risc_isa_pkg::*, risc_ctrl_pkg::*;
();

  localparam int num_progs   = 24;                        // every fourth one traps
  localparam int cycle_limit = num_progs * (40 * 3 + 20);

  logic                clk;
  logic                reset;
  word_t               mem_rdata;
  word_t               mem_addr;
  word_t               mem_wdata;
  logic                mem_we;
  logic [status_w-1:0] status;

  word_t mem [256];   // external memory, low 8 address bits
  int    errors;
  int    checks;
  int    cycles = 0;

  `include "risc_ref_model.svh"

  risc_cpu i_risc_cpu (
    .clk       (clk),
    .reset     (reset),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we),
    .status    (status)
  );

  assign mem_rdata = mem[mem_addr[7:0]];  // same-cycle read

  always @(posedge clk)
    if (mem_we)
      mem[mem_addr[7:0]] <= mem_wdata;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the core never finished its programs", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string what, input word_t got, input word_t exp);
    checks++;
    assert (got === exp)
    else begin
      errors++;
      $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // follow stores until halt or trap, then watch the core sit still
  task automatic run_program();
    logic [status_w-1:0] final_status;
    bit                  stopped;
    final_status = m_illegal ? status_illegal : {m_flags, 5'h0b};  // halt code under flags
    stopped      = 1'b0;
    while (!stopped) begin
      @(negedge clk);
      if (mem_we) begin
        assert (exp_addr.size() > 0)
        else begin
          errors++;
          $display("error %0t: store to %h after the model ran out of stores", $time, mem_addr);
        end
        if (exp_addr.size() > 0) begin
          check_value("store address", mem_addr, exp_addr.pop_front());
          check_value("store data", mem_wdata, exp_data.pop_front());
        end
      end
      stopped = (status[4:0] == 5'h0b) || (status == status_illegal);
    end
    check_value("final status", status, final_status);
    assert (exp_addr.size() == 0)
    else begin
      errors++;
      $display("error %0t: core stopped with %0d stores missing", $time, exp_addr.size());
    end
    repeat (10) begin
      @(negedge clk);
      check_value("status after stop", status, final_status);
      check_value("mem_we after stop", mem_we, 1'b0);
    end
  endtask

  initial begin
    reset  = 1'b1;
    errors = 0;
    checks = 0;
    void'($urandom(52249));
    for (int i = 0; i < 256; i++)
      mem[i] = '0;
    for (int p = 0; p < num_progs; p++) begin
      gen_program(p % 4 == 3);
      run_model();
      @(posedge clk);
      #1;
      reset = 1'b1;
      for (int i = 0; i < 256; i++)
        mem[i] = prog_img[i];             // core idle in halt or trap
      repeat (5) begin
        @(negedge clk);
        check_value("status in reset", status, status_reset);
        check_value("mem_we in reset", mem_we, 1'b0);
      end
      @(posedge clk);
      #1;
      reset = 1'b0;
      run_program();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: src/alu.sv
module alu
  import risc_isa_pkg::*;
(
  input  alu_op_e alu_op,
  input  word_t   r_data,
  input  word_t   s_data,
  output word_t   y,
  output flags_t  flags
);

  logic [word_w:0] ext;  // msb is carry, borrow or shifted-out bit

  always_comb begin
    case (alu_op)
      alu_add: ext = {1'b0, r_data} + {1'b0, s_data};    // carry out
      alu_sub: ext = {1'b0, r_data} - {1'b0, s_data};    // borrow on r < s
      alu_inc: ext = {1'b0, s_data} + (word_w + 1)'(1);
      alu_dec: ext = {1'b0, s_data} - (word_w + 1)'(1);  // borrow at zero
      alu_shl: ext = {s_data, 1'b0};                     // msb falls out
      alu_shr: ext = {s_data[0], 1'b0, s_data[word_w-1:1]};  // lsb into carry
      default: ext = {1'b0, s_data};                     // pass, no carry
    endcase
  end

  assign y = ext[word_w-1:0];

  always_comb begin
    flags.n = y[word_w-1];
    flags.z = (y == '0);
    flags.c = ext[word_w];
  end

endmodule

// File: src/control_unit.sv
module control_unit
  import risc_isa_pkg::*, risc_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  word_t               ir,
  input  flags_t              alu_flags,
  output ctrl_word_t          ctrl,
  output logic [status_w-1:0] status
);

  cu_state_e            state;       // present state
  cu_state_e            next_state;
  cu_state_e            dec_state;   // target of decode
  flags_t               flags_q;     // stored flags
  logic                 flag_ld;     // take alu flags this cycle
  logic [state_w-1:0]   exec_code;   // low status bits in execute

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= st_reset;
      flags_q <= '0;
    end else begin
      state <= next_state;
      if (flag_ld)
        flags_q <= alu_flags;  // end of a flag-setting state
    end
  end

  assign exec_code = state_w'(op_of(ir) - op_add);  // ir holds still after fetch

  // opcode to execute state
  always_comb begin
    case (op_of(ir))
      op_add:  dec_state = st_add;
      op_sub:  dec_state = st_sub;
      op_cmp:  dec_state = st_cmp;
      op_mov:  dec_state = st_mov;
      op_shl:  dec_state = st_shl;
      op_shr:  dec_state = st_shr;
      op_inc:  dec_state = st_inc;
      op_dec:  dec_state = st_dec;
      op_ld:   dec_state = st_ld;
      op_sto:  dec_state = st_sto;
      op_ldi:  dec_state = st_ldi;
      op_halt: dec_state = st_halt;
      op_je:   dec_state = st_je;
      op_jne:  dec_state = st_jne;
      op_jc:   dec_state = st_jc;
      op_jmp:  dec_state = st_jmp;
      default: dec_state = st_illegal;  // below 0x70 traps
    endcase
  end

  // moore outputs and next state
  always_comb begin
    ctrl        = '0;                  // all strobes idle
    ctrl.alu_op = alu_pass;
    status      = {flags_q, exec_code};  // execute pattern
    next_state  = st_fetch;            // execute states return to fetch
    flag_ld     = 1'b0;
    case (state)
      st_reset: status = status_reset;
      st_fetch: begin
        ctrl.pc_inc = 1'b1;            // pc <- pc + 1
        ctrl.ir_ld  = 1'b1;            // ir <- M[pc]
        status      = status_fetch;
        next_state  = st_decode;
      end
      st_decode: begin
        status     = status_decode;
        next_state = dec_state;
      end
      st_add, st_sub, st_cmp: begin
        ctrl.w_adr  = w_of(ir);
        ctrl.r_adr  = r_of(ir);
        ctrl.s_adr  = s_of(ir);
        ctrl.rw_en  = (state != st_cmp);  // cmp only sets flags
        ctrl.alu_op = (state == st_add) ? alu_add : alu_sub;
        flag_ld     = 1'b1;
      end
      st_shl, st_shr, st_inc, st_dec: begin
        ctrl.w_adr = w_of(ir);
        ctrl.s_adr = s_of(ir);         // single operand on s port
        ctrl.rw_en = 1'b1;
        case (state)
          st_shl:  ctrl.alu_op = alu_shl;
          st_shr:  ctrl.alu_op = alu_shr;
          st_inc:  ctrl.alu_op = alu_inc;
          default: ctrl.alu_op = alu_dec;
        endcase
        flag_ld = 1'b1;
      end
      st_mov: begin
        ctrl.w_adr = w_of(ir);
        ctrl.s_adr = s_of(ir);         // pass R[s] through alu
        ctrl.rw_en = 1'b1;
      end
      st_ld: begin
        ctrl.w_adr   = w_of(ir);
        ctrl.r_adr   = s_of(ir);       // address R[s] via r port
        ctrl.adr_sel = 1'b1;
        ctrl.s_sel   = 1'b1;           // write back memory word
        ctrl.rw_en   = 1'b1;
      end
      st_sto: begin
        ctrl.r_adr   = w_of(ir);       // address R[w]
        ctrl.s_adr   = s_of(ir);       // data R[s]
        ctrl.adr_sel = 1'b1;
        ctrl.mw_en   = 1'b1;
      end
      st_ldi: begin
        ctrl.w_adr  = w_of(ir);
        ctrl.s_sel  = 1'b1;            // immediate word at M[pc]
        ctrl.rw_en  = 1'b1;
        ctrl.pc_inc = 1'b1;            // skip the immediate
      end
      st_je:  ctrl.pc_ld = flags_q.z;
      st_jne: ctrl.pc_ld = !flags_q.z;
      st_jc:  ctrl.pc_ld = flags_q.c;
      st_jmp: begin
        ctrl.s_adr  = s_of(ir);
        ctrl.pc_ld  = 1'b1;
        ctrl.pc_sel = 1'b1;            // pc <- R[s]
      end
      st_halt: next_state = st_halt;   // flags kept
      st_illegal: begin
        status     = status_illegal;
        next_state = st_illegal;
      end
      default: begin
        status     = status_illegal;   // unused encodings
        next_state = st_illegal;
      end
    endcase
  end

  a_pc_ld_inc: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.pc_ld && ctrl.pc_inc));

  a_mw_rw: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.mw_en && ctrl.rw_en));

  // halt and illegal only left through reset
  a_absorb: assert property (@(posedge clk) disable iff (reset)
    (state inside {st_halt, st_illegal}) |=> (state == $past(state)));

endmodule

// File: src/fetch_unit.sv
module fetch_unit
  import risc_isa_pkg::*, risc_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  ctrl_word_t ctrl,
  input  word_t      mem_rdata,
  input  word_t      r_data,
  input  word_t      s_data,
  output word_t      pc,
  output word_t      ir,
  output word_t      mem_addr
);

  word_t pc_next;  // branch or jump target

  assign pc_next  = ctrl.pc_sel ? s_data : (pc + off_of(ir));  // relative to pc after fetch
  assign mem_addr = ctrl.adr_sel ? r_data : pc;               // data access or instruction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else if (ctrl.pc_inc) begin
      pc <= pc + word_t'(1);       // fetch and ldi step
    end else if (ctrl.pc_ld) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ir <= '0;
    else if (ctrl.ir_ld)
      ir <= mem_rdata;             // M[pc] in fetch
  end

  // ir loads only in fetch, where pc steps too
  a_ir_ld_inc: assert property (@(posedge clk) disable iff (reset)
    ctrl.ir_ld |-> ctrl.pc_inc);

endmodule

// File: src/register_file.sv
module register_file
  import risc_isa_pkg::*, risc_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  ctrl_word_t ctrl,
  input  word_t      alu_y,
  input  word_t      mem_rdata,
  output word_t      r_data,
  output word_t      s_data
);

  word_t regs [num_regs];  // R0..R7
  word_t wb_data;          // write-back source

  assign wb_data = ctrl.s_sel ? mem_rdata : alu_y;  // ld/ldi take memory

  // two combinational read ports
  assign r_data = regs[ctrl.r_adr];
  assign s_data = regs[ctrl.s_adr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;
    end else if (ctrl.rw_en) begin
      regs[ctrl.w_adr] <= wb_data;  // end of execute
    end
  end

endmodule

// File: src/risc_cpu.sv
module risc_cpu
  import risc_isa_pkg::*, risc_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  word_t               mem_rdata,
  output word_t               mem_addr,
  output word_t               mem_wdata,
  output logic                mem_we,
  output logic [status_w-1:0] status
);

  ctrl_word_t ctrl;       // control word to datapath
  word_t      ir;
  word_t      r_data;
  word_t      s_data;
  word_t      y;          // alu result
  flags_t     alu_flags;

  control_unit i_control_unit (
    .clk       (clk),
    .reset     (reset),
    .ir        (ir),
    .alu_flags (alu_flags),
    .ctrl      (ctrl),
    .status    (status)
  );

  fetch_unit i_fetch_unit (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .mem_rdata (mem_rdata),
    .r_data    (r_data),
    .s_data    (s_data),
    .pc        (),
    .ir        (ir),
    .mem_addr  (mem_addr)
  );

  register_file i_register_file (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .alu_y     (y),
    .mem_rdata (mem_rdata),
    .r_data    (r_data),
    .s_data    (s_data)
  );

  alu i_alu (
    .alu_op (ctrl.alu_op),
    .r_data (r_data),
    .s_data (s_data),
    .y      (y),
    .flags  (alu_flags)
  );

  assign mem_wdata = s_data;      // sto data is R[s]
  assign mem_we    = ctrl.mw_en;

endmodule

// File: src/risc_ctrl_pkg.sv
package risc_ctrl_pkg;
  import risc_isa_pkg::*;

  localparam int state_w  = 5;  // state and status code width
  localparam int status_w = 8;  // led pattern width

  localparam logic [status_w-1:0] status_reset   = 8'hFF;
  localparam logic [status_w-1:0] status_fetch   = 8'h80;
  localparam logic [status_w-1:0] status_decode  = 8'hC0;
  localparam logic [status_w-1:0] status_illegal = 8'hF0;

  // execute states follow opcode order
  typedef enum logic [state_w-1:0] {
    st_reset   = 5'd0,
    st_fetch   = 5'd1,
    st_decode  = 5'd2,
    st_add     = 5'd3,
    st_sub, st_cmp, st_mov, st_shl, st_shr, st_inc, st_dec,
    st_ld, st_sto, st_ldi, st_halt,
    st_je, st_jne, st_jc, st_jmp,
    st_illegal = 5'd31
  } cu_state_e;

  typedef struct packed {
    reg_adr_t w_adr;    // write port index
    reg_adr_t r_adr;    // r read port index
    reg_adr_t s_adr;    // s read port index
    logic     adr_sel;  // 0 pc, 1 r_data
    logic     s_sel;    // 0 alu y, 1 mem_rdata
    logic     pc_ld;    // branch / jump load
    logic     pc_inc;
    logic     pc_sel;   // 0 pc + offset, 1 s_data
    logic     ir_ld;
    logic     mw_en;    // memory write strobe
    logic     rw_en;    // register write strobe
    alu_op_e  alu_op;
  } ctrl_word_t;

endpackage

// File: src/risc_isa_pkg.sv
package risc_isa_pkg;

  localparam int word_w    = 16;  // data and address width
  localparam int reg_adr_w = 3;   // register index width
  localparam int num_regs  = 8;   // register file depth
  localparam int op_w      = 7;   // opcode field width

  // instruction word field positions
  localparam int op_msb  = 15;
  localparam int op_lsb  = 9;
  localparam int w_msb   = 8;
  localparam int w_lsb   = 6;
  localparam int r_msb   = 5;
  localparam int r_lsb   = 3;
  localparam int s_msb   = 2;
  localparam int s_lsb   = 0;
  localparam int off_msb = 7;     // relative jump offset, sign-extended
  localparam int off_lsb = 0;

  typedef logic [word_w-1:0]    word_t;
  typedef logic [reg_adr_w-1:0] reg_adr_t;

  typedef enum logic [op_w-1:0] {
    op_add  = 7'h70,  // R[w] <- R[r] + R[s]
    op_sub  = 7'h71,  // R[w] <- R[r] - R[s]
    op_cmp  = 7'h72,  // flags of R[r] - R[s]
    op_mov  = 7'h73,  // R[w] <- R[s]
    op_shl  = 7'h74,
    op_shr  = 7'h75,
    op_inc  = 7'h76,
    op_dec  = 7'h77,
    op_ld   = 7'h78,  // R[w] <- M[R[s]]
    op_sto  = 7'h79,  // M[R[w]] <- R[s]
    op_ldi  = 7'h7a,  // R[w] <- M[pc], pc++
    op_halt = 7'h7b,
    op_je   = 7'h7c,
    op_jne  = 7'h7d,
    op_jc   = 7'h7e,
    op_jmp  = 7'h7f   // pc <- R[s]
  } opcode_e;

  typedef enum logic [3:0] {
    alu_pass = 4'h0,  // y = s
    alu_inc  = 4'h2,
    alu_dec  = 4'h3,
    alu_add  = 4'h4,
    alu_sub  = 4'h5,
    alu_shr  = 4'h6,
    alu_shl  = 4'h7
  } alu_op_e;

  typedef struct packed {
    logic n;  // negative
    logic z;  // zero
    logic c;  // carry / borrow / shifted-out bit
  } flags_t;

  function automatic logic [op_w-1:0] op_of(input word_t ir);
    return ir[op_msb:op_lsb];
  endfunction

  function automatic reg_adr_t w_of(input word_t ir);
    return ir[w_msb:w_lsb];
  endfunction

  function automatic reg_adr_t r_of(input word_t ir);
    return ir[r_msb:r_lsb];
  endfunction

  function automatic reg_adr_t s_of(input word_t ir);
    return ir[s_msb:s_lsb];
  endfunction

  function automatic word_t off_of(input word_t ir);
    return word_t'($signed(ir[off_msb:off_lsb]));  // sign extend
  endfunction

endpackage
